// ==== hdl/pco_config.svh ====
`ifndef PCO_CONFIG_SVH
`define PCO_CONFIG_SVH

`define CNTR_W          13 // oscillator and controller counters
`define SEQ_LEN         16 // encoded sequence length
`define SEQ_IDX_W       4  // index into the sequence
`define WB_AW           4
`define WB_DW           16

`define REG_CTRL        4'd0
`define REG_NDELAY      4'd1
`define REG_NBLACKOUT   4'd2
`define REG_NCSTR       4'd3
`define REG_NPCO        4'd4
`define REG_NDUTY_L     4'd5
`define REG_NDUTY_H     4'd6
`define REG_NPULSE      4'd7
`define REG_NDUTY       4'd8
`define REG_SEQ         4'd9
`define REG_STATUS      4'd10

`define CTRL_PCO_EN     0
`define CTRL_DUTY_EN    1
`define CTRL_GEN_EN     2
`define CTRL_DESIGN_SEL 3

`define NPCO_RST        13'd1 // npco after reset, every other field clears

`endif

// ==== hdl/pco_pkg.sv ====
`default_nettype none

`include "pco_config.svh"

package pco_pkg;

	typedef logic [`CNTR_W-1:0] cntr_t;
	typedef logic [`SEQ_IDX_W-1:0] seq_idx_t;

	localparam seq_idx_t SEQ_LAST = seq_idx_t'(`SEQ_LEN - 1); // idle position of the generator

	// wishbone classic, master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`WB_AW-1:0] adr;
		logic [`WB_DW-1:0] dat_w;
	} wb_req_t;

	// slave side
	typedef struct packed {
		logic ack;
		logic [`WB_DW-1:0] dat_r;
	} wb_rsp_t;

	typedef struct packed {
		logic en;
		logic design_sel; // delay counter reload after forced reset
		cntr_t ndelay;
		cntr_t nblackout;
		cntr_t ncstr; // coupling strength
		cntr_t npco; // phase threshold
	} pco_cfg_t;

	typedef struct packed {
		logic en;
		cntr_t nduty_l; // duty window low edge
		cntr_t nduty_h;
		cntr_t npulse; // resets needed to declare sync
		cntr_t nduty; // pco cycles of duty before check
	} duty_cfg_t;

	typedef struct packed {
		logic en;
		logic [`SEQ_LEN-1:0] seq; // msb goes out first
	} gen_cfg_t;

	typedef struct packed {
		logic pulse; // any oscillator reset
		logic forced; // reset caused by coupling
		cntr_t count;
	} pco_evt_t;

	typedef enum logic [2:0] {
		IDLE        = 3'd0,
		DESYNC      = 3'd1,
		SYNC_LEAD   = 3'd2,
		SYNC_SLAVE  = 3'd3,
		CHECK_LEAD  = 3'd4,
		CHECK_SLAVE = 3'd5
	} duty_state_t;

endpackage

`default_nettype wire

// ==== hdl/pco_regs.sv ====
`default_nettype none

`include "pco_config.svh"

module pco_regs import pco_pkg::*; (
	input  logic        clk,
	input  logic        greset_n,
	input  wb_req_t     wb_req,
	output wb_rsp_t     wb_rsp,
	input  duty_state_t state,
	input  logic        duty,
	output pco_cfg_t    pco_cfg,
	output duty_cfg_t   duty_cfg,
	output gen_cfg_t    gen_cfg
);

	logic req; // cycle requested by master
	logic ack_q;
	logic wr_en;
	logic [`WB_DW-1:0] rd_data;
	logic [`CNTR_W-1:0] wr_cntr; // write data cut to counter width

	assign req = wb_req.cyc && wb_req.stb;
	assign wr_en = ack_q && req && wb_req.we; // store on the edge that ends ack
	assign wr_cntr = wb_req.dat_w[`CNTR_W-1:0];

	// single wait cycle, ack lasts one clock
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req && !ack_q;
		end
	end

	// configuration registers
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			pco_cfg <= '0;
			pco_cfg.npco <= `NPCO_RST;
			duty_cfg <= '0;
			gen_cfg <= '0;
		end else if (wr_en) begin
			case (wb_req.adr)
				`REG_CTRL: begin
					pco_cfg.en <= wb_req.dat_w[`CTRL_PCO_EN];
					duty_cfg.en <= wb_req.dat_w[`CTRL_DUTY_EN];
					gen_cfg.en <= wb_req.dat_w[`CTRL_GEN_EN];
					pco_cfg.design_sel <= wb_req.dat_w[`CTRL_DESIGN_SEL];
				end
				`REG_NDELAY:    pco_cfg.ndelay <= wr_cntr;
				`REG_NBLACKOUT: pco_cfg.nblackout <= wr_cntr;
				`REG_NCSTR:     pco_cfg.ncstr <= wr_cntr;
				`REG_NPCO:      pco_cfg.npco <= wr_cntr;
				`REG_NDUTY_L:   duty_cfg.nduty_l <= wr_cntr;
				`REG_NDUTY_H:   duty_cfg.nduty_h <= wr_cntr;
				`REG_NPULSE:    duty_cfg.npulse <= wr_cntr;
				`REG_NDUTY:     duty_cfg.nduty <= wr_cntr;
				`REG_SEQ:       gen_cfg.seq <= wb_req.dat_w;
				default: ; // status and holes are read only
			endcase
		end
	end

	// read mux, only looked at while ack is high
	always_comb begin
		rd_data = '0;
		case (wb_req.adr)
			`REG_CTRL: begin
				rd_data[`CTRL_PCO_EN] = pco_cfg.en;
				rd_data[`CTRL_DUTY_EN] = duty_cfg.en;
				rd_data[`CTRL_GEN_EN] = gen_cfg.en;
				rd_data[`CTRL_DESIGN_SEL] = pco_cfg.design_sel;
			end
			`REG_NDELAY:    rd_data[`CNTR_W-1:0] = pco_cfg.ndelay;
			`REG_NBLACKOUT: rd_data[`CNTR_W-1:0] = pco_cfg.nblackout;
			`REG_NCSTR:     rd_data[`CNTR_W-1:0] = pco_cfg.ncstr;
			`REG_NPCO:      rd_data[`CNTR_W-1:0] = pco_cfg.npco;
			`REG_NDUTY_L:   rd_data[`CNTR_W-1:0] = duty_cfg.nduty_l;
			`REG_NDUTY_H:   rd_data[`CNTR_W-1:0] = duty_cfg.nduty_h;
			`REG_NPULSE:    rd_data[`CNTR_W-1:0] = duty_cfg.npulse;
			`REG_NDUTY:     rd_data[`CNTR_W-1:0] = duty_cfg.nduty;
			`REG_SEQ:       rd_data = gen_cfg.seq;
			`REG_STATUS: begin
				rd_data[2:0] = state; // live controller state
				rd_data[3] = duty;
			end
			default: rd_data = '0;
		endcase
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat_r = rd_data;

endmodule

`default_nettype wire

// ==== hdl/pco_osc.sv ====
`default_nettype none

`include "pco_config.svh"

// progressively slowing oscillator
// period is roughly ndelay + npco*(npco-1)/2 clocks when free running
module pco_osc import pco_pkg::*; (
	input  logic     clk,
	input  logic     greset_n,
	input  logic     peak_in,
	input  pco_cfg_t cfg,
	output pco_evt_t evt
);

	logic [1:0] peak_sync; // two flop synchronizer
	logic peak_prev;
	logic edge_q; // registered rising edge, 3 clocks after peak_in
	cntr_t count; // phase
	cntr_t del_cnt;
	cntr_t trig_cnt;
	logic cpulse; // coupling pulse outside blackout
	logic trig; // slowing trigger tick
	logic trig_en;
	logic cpulse_rst;
	logic trig_rst;
	logic forced;
	logic pulse;

	assign cpulse = edge_q && (count > cfg.nblackout);
	assign trig_en = (del_cnt == cfg.ndelay);
	assign trig = ((trig_cnt + 1'b1) == count) && trig_en;
	assign cpulse_rst = ({1'b0, count} + {1'b0, cfg.ncstr}) >= {1'b0, cfg.npco}; // no wrap
	assign trig_rst = (count + 1'b1) == cfg.npco;

	// no events while frozen
	assign forced = cfg.en && cpulse && cpulse_rst;
	assign pulse = forced || (cfg.en && trig && trig_rst);

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			peak_sync <= 2'b00;
			peak_prev <= 1'b0;
			edge_q <= 1'b0;
		end else if (cfg.en) begin
			peak_sync <= {peak_sync[0], peak_in};
			peak_prev <= peak_sync[1];
			edge_q <= peak_sync[1] && !peak_prev; // one clock per rising edge
		end
	end

	// delay before triggers start
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			del_cnt <= '0;
		end else if (cfg.en) begin
			if (pulse) begin
				del_cnt <= (cfg.design_sel && forced) ? cntr_t'(1) : '0;
			end else if (del_cnt != cfg.ndelay) begin
				del_cnt <= del_cnt + 1'b1;
			end
		end
	end

	// wraps at count, so ticks get sparser as count grows
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			trig_cnt <= '0;
		end else if (cfg.en) begin
			if (pulse || ((trig_cnt + 1'b1) == count)) begin
				trig_cnt <= '0;
			end else begin
				trig_cnt <= trig_cnt + 1'b1;
			end
		end
	end

	// phase counter, coupling wins over trigger
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			count <= cntr_t'(1);
		end else if (cfg.en) begin
			if (pulse) begin
				count <= cntr_t'(1);
			end else if (cpulse) begin
				count <= count + cfg.ncstr; // coupling jump
			end else if (trig) begin
				count <= count + 1'b1;
			end
		end
	end

	assign evt.pulse = pulse;
	assign evt.forced = forced;
	assign evt.count = count;

endmodule

`default_nettype wire

// ==== hdl/duty_ctrl.sv ====
`default_nettype none

// duty-cycle controller
// waits for npulse lead or slave resets in a row, then opens the duty window
// for nduty oscillator cycles and rechecks sync
module duty_ctrl import pco_pkg::*; (
	input  logic        clk,
	input  logic        greset_n,
	input  pco_evt_t    evt,
	input  duty_cfg_t   cfg,
	output duty_state_t state,
	output logic        duty_out
);

	duty_state_t next_state;
	cntr_t lead_cnt; // natural resets seen
	cntr_t slave_cnt; // late forced resets seen
	cntr_t len_cnt; // pulses since sync
	logic natural_rst;
	logic forced_rst;
	logic in_sync;
	logic in_window;
	logic trk_clr;
	logic len_clr;

	assign natural_rst = evt.pulse && !evt.forced;
	assign forced_rst = evt.pulse && evt.forced;
	assign in_sync = (state == SYNC_LEAD) || (state == SYNC_SLAVE);
	assign in_window = (evt.count >= cfg.nduty_l) && (evt.count <= cfg.nduty_h);

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			duty_out <= 1'b0;
		end else if (cfg.en) begin
			duty_out <= in_sync && in_window; // one clock behind the compare
		end
	end

	// reset tracker
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			lead_cnt <= '0;
			slave_cnt <= '0;
		end else if (cfg.en) begin
			if (trk_clr) begin
				lead_cnt <= '0;
				slave_cnt <= '0;
			end else if (forced_rst) begin
				if (evt.count <= cfg.nduty_h) begin // early, likely a stray node
					lead_cnt <= '0;
					slave_cnt <= '0;
				end else begin
					slave_cnt <= slave_cnt + 1'b1; // a faster neighbour
				end
			end else if (natural_rst) begin
				lead_cnt <= lead_cnt + 1'b1;
			end
		end
	end

	// duty length, saturates one past nduty
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			len_cnt <= '0;
		end else if (cfg.en) begin
			if (len_clr) begin
				len_cnt <= '0;
			end else if (evt.pulse && in_sync && (len_cnt <= cfg.nduty)) begin
				len_cnt <= len_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			state <= IDLE;
		end else if (cfg.en) begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		trk_clr = 1'b0;
		len_clr = 1'b0;
		case (state)
			IDLE: begin
				next_state = DESYNC; // only reached while enabled
				trk_clr = 1'b1;
			end
			DESYNC: begin
				if (lead_cnt == cfg.npulse) begin
					next_state = SYNC_LEAD;
					len_clr = 1'b1;
				end else if (slave_cnt == cfg.npulse) begin
					next_state = SYNC_SLAVE;
					len_clr = 1'b1;
				end
			end
			SYNC_LEAD: begin
				if (len_cnt > cfg.nduty) next_state = CHECK_LEAD;
			end
			SYNC_SLAVE: begin
				if (len_cnt > cfg.nduty) next_state = CHECK_SLAVE;
			end
			CHECK_LEAD: begin
				if (natural_rst) begin // still the fastest node
					next_state = SYNC_LEAD;
					len_clr = 1'b1;
				end else if (forced_rst) begin
					next_state = DESYNC;
					trk_clr = 1'b1;
				end
			end
			CHECK_SLAVE: begin
				if (forced_rst) begin // still pulled by the leader
					next_state = SYNC_SLAVE;
					len_clr = 1'b1;
				end else if (natural_rst) begin
					next_state = DESYNC;
					trk_clr = 1'b1;
				end
			end
			default: next_state = IDLE;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/seq_pulsegen.sv ====
`default_nettype none

module seq_pulsegen import pco_pkg::*; (
	input  logic     clk,
	input  logic     greset_n,
	input  pco_evt_t evt,
	input  gen_cfg_t cfg,
	output logic     seq_out
);

	seq_idx_t idx; // bit being sent, SEQ_LAST when idle
	seq_idx_t bit_sel;

	assign bit_sel = SEQ_LAST - idx; // msb first
	assign seq_out = cfg.seq[bit_sel];

	// restart only when idle, otherwise run to the end and hold
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			idx <= SEQ_LAST;
		end else if (cfg.en) begin
			if (evt.pulse && (idx == SEQ_LAST)) begin
				idx <= '0;
			end else if (idx != SEQ_LAST) begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pco_node_top.sv ====
`default_nettype none

// pco node, register block plus oscillator, controller and sequence output
module pco_node_top import pco_pkg::*; (
	input  logic        clk,
	input  logic        greset_n,
	input  wb_req_t     wb_req,
	output wb_rsp_t     wb_rsp,
	input  logic        peak_in, // raw peak, synchronized inside the oscillator
	output pco_evt_t    evt,
	output duty_state_t state,
	output logic        duty_out,
	output logic        seq_out
);

	pco_cfg_t pco_cfg;
	duty_cfg_t duty_cfg;
	gen_cfg_t gen_cfg;

	pco_regs u_pco_regs (
		.clk      (clk),
		.greset_n (greset_n),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.state    (state),
		.duty     (duty_out),
		.pco_cfg  (pco_cfg),
		.duty_cfg (duty_cfg),
		.gen_cfg  (gen_cfg)
	);

	pco_osc u_pco_osc (
		.clk      (clk),
		.greset_n (greset_n),
		.peak_in  (peak_in),
		.cfg      (pco_cfg),
		.evt      (evt)
	);

	duty_ctrl u_duty_ctrl (
		.clk      (clk),
		.greset_n (greset_n),
		.evt      (evt),
		.cfg      (duty_cfg),
		.state    (state),
		.duty_out (duty_out)
	);

	seq_pulsegen u_seq_pulsegen (
		.clk      (clk),
		.greset_n (greset_n),
		.evt      (evt), // restarts on any reset
		.cfg      (gen_cfg),
		.seq_out  (seq_out)
	);

endmodule

`default_nettype wire

// ==== testbench/pco_node_chk.sv ====
`default_nettype none

module pco_node_chk import pco_pkg::*; (
	input logic        clk,
	input logic        greset_n,
	input wb_rsp_t     wb_rsp,
	input pco_evt_t    evt,
	input duty_state_t state,
	input logic        duty_out
);

	timeunit 1ns;
	timeprecision 1ps;

	ack_one_cycle: assert property (@(posedge clk) disable iff (!greset_n)
		wb_rsp.ack |=> !wb_rsp.ack) else $error("ack stayed high past one clock");

	forced_has_pulse: assert property (@(posedge clk) disable iff (!greset_n)
		evt.forced |-> evt.pulse) else $error("forced reset without pulse");

	duty_held_after_sync: assert property (@(posedge clk) disable iff (!greset_n)
		duty_out |-> (state == SYNC_LEAD || state == SYNC_SLAVE
			|| state == CHECK_LEAD || state == CHECK_SLAVE))
		else $error("duty_out high while idle or desynchronized");

endmodule

bind pco_node_top pco_node_chk u_pco_node_chk (.*);

`default_nettype wire

// ==== testbench/tb_pco_node.sv ====
`default_nettype none

`include "pco_config.svh"

module tb_pco_node import pco_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	typedef logic [`WB_AW-1:0] adr_t;
	typedef logic [`WB_DW-1:0] word_t;

	localparam int NUM_RUNS = 8;
	localparam int RUN_CYCLES = 3000; // one random oscillator run
	localparam int FREEZE_CYCLES = 300;
	localparam int TEST_CYCLES = NUM_RUNS * (RUN_CYCLES + 2 * FREEZE_CYCLES + 80) + 200;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic clk;
	logic greset_n;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic peak_in;
	pco_evt_t evt;
	duty_state_t state;
	logic duty_out;
	logic seq_out;

	int unsigned cfg_seed;
	int unsigned peak_seed; // separate stream for the peak driver
	int peak_rate; // 0 means no peaks
	int peak_hold;
	int cycle_count;
	int error_count;

	// cycle model state
	pco_cfg_t m_pcfg;
	duty_cfg_t m_dcfg;
	gen_cfg_t m_gcfg;
	logic m_ack;
	logic m_s0, m_s1, m_prev, m_edge; // peak synchronizer and edge detect
	cntr_t m_count, m_del, m_trig_cnt;
	logic m_cpulse, m_trig;
	pco_evt_t m_evt;
	duty_state_t m_state, m_next;
	logic m_duty, m_nat, m_frc, m_in_sync, m_trk_clr, m_len_clr;
	cntr_t m_lead, m_slave, m_len;
	int m_idx; // generator bit index

	pco_node_top u_pco_node_top (
		.clk      (clk),
		.greset_n (greset_n),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.peak_in  (peak_in),
		.evt      (evt),
		.state    (state),
		.duty_out (duty_out),
		.seq_out  (seq_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// value in 0 .. bound-1 from the config stream
	function automatic int unsigned draw(input int unsigned bound);
		cfg_seed = lcg_next(cfg_seed);
		return (cfg_seed >> 16) % bound;
	endfunction

	task automatic stop_on_error(input string msg);
		error_count++;
		$display("ERROR at time %0t: %s", $time, msg);
		$display("Test failures found");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_evt(input pco_evt_t got, input pco_evt_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("evt pulse/forced/count %b/%b/%0d, expected %b/%b/%0d",
				got.pulse, got.forced, got.count, exp.pulse, exp.forced, exp.count));
		end
	endtask

	task automatic check_state(input duty_state_t got, input duty_state_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("state %s, expected %s", got.name(), exp.name()));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_word(input word_t got, input word_t exp, input adr_t adr);
		if (got !== exp) begin
			stop_on_error($sformatf("read of reg %0d gave %h, expected %h", adr, got, exp));
		end
	endtask

	// expected read data from the model registers
	function automatic word_t exp_read(input adr_t adr);
		word_t d;
		d = '0;
		case (adr)
			`REG_CTRL: begin
				d[`CTRL_PCO_EN] = m_pcfg.en;
				d[`CTRL_DUTY_EN] = m_dcfg.en;
				d[`CTRL_GEN_EN] = m_gcfg.en;
				d[`CTRL_DESIGN_SEL] = m_pcfg.design_sel;
			end
			`REG_NDELAY:    d[`CNTR_W-1:0] = m_pcfg.ndelay;
			`REG_NBLACKOUT: d[`CNTR_W-1:0] = m_pcfg.nblackout;
			`REG_NCSTR:     d[`CNTR_W-1:0] = m_pcfg.ncstr;
			`REG_NPCO:      d[`CNTR_W-1:0] = m_pcfg.npco;
			`REG_NDUTY_L:   d[`CNTR_W-1:0] = m_dcfg.nduty_l;
			`REG_NDUTY_H:   d[`CNTR_W-1:0] = m_dcfg.nduty_h;
			`REG_NPULSE:    d[`CNTR_W-1:0] = m_dcfg.npulse;
			`REG_NDUTY:     d[`CNTR_W-1:0] = m_dcfg.nduty;
			`REG_SEQ:       d = m_gcfg.seq;
			`REG_STATUS:    d[3:0] = {m_duty, m_state};
			default:        d = '0; // holes read zero
		endcase
		return d;
	endfunction

	// one classic cycle with ack due one clock after the request
	task automatic bus_cycle(input logic we, input adr_t adr, input int unsigned dat);
		int waits;
		@(posedge clk);
		#1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat_w = word_t'(dat);
		waits = 0;
		do begin
			@(negedge clk);
			waits++;
			if (waits > 8) begin
				$display("no ack from the register block within 8 cycles of a request");
				$display("Test failures found");
				$fatal(1, "bus hang");
			end
		end while (!wb_rsp.ack);
		if (waits != 2) begin
			stop_on_error($sformatf("ack came %0d cycles after the request", waits - 1));
		end
		if (!we) begin
			check_word(wb_rsp.dat_r, exp_read(adr), adr); // status sampled live
		end
		@(posedge clk); // write lands here
		#1;
		wb_req = '0;
	endtask

	task automatic bus_write(input adr_t adr, input int unsigned dat);
		bus_cycle(1'b1, adr, dat);
	endtask

	task automatic bus_read(input adr_t adr);
		bus_cycle(1'b0, adr, 0);
	endtask

	task automatic apply_reset();
		greset_n = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		greset_n = 1'b1;
	endtask

	task automatic run_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic test_registers();
		bus_read(`REG_STATUS); // idle and duty low out of reset
		for (int a = 0; a <= `REG_SEQ; a++) begin
			bus_write(adr_t'(a), draw(65536));
			bus_read(adr_t'(a));
		end
		for (int a = `REG_STATUS + 1; a < 16; a++) begin
			bus_read(adr_t'(a));
		end
	endtask

	// random legal config and a run before one block is frozen and released
	task automatic random_run(input int r);
		int unsigned npco;
		int unsigned nduty_h;
		logic [3:0] ctrl;
		peak_rate = 0;
		apply_reset();
		npco = 6 + draw(19);
		nduty_h = draw(npco);
		bus_write(`REG_NDELAY, draw(16));
		bus_write(`REG_NBLACKOUT, draw(npco));
		bus_write(`REG_NCSTR, 1 + draw(npco - 1)); // strictly below npco
		bus_write(`REG_NPCO, npco);
		bus_write(`REG_NDUTY_L, draw(nduty_h + 1));
		bus_write(`REG_NDUTY_H, nduty_h);
		bus_write(`REG_NPULSE, 1 + draw(3));
		bus_write(`REG_NDUTY, draw(4));
		bus_write(`REG_SEQ, draw(65536));
		ctrl = 4'b0111;
		ctrl[`CTRL_DESIGN_SEL] = r[0];
		bus_write(`REG_CTRL, ctrl);
		peak_rate = (r < 2) ? 0 : 40 + int'(draw(80)); // first two runs free running
		run_cycles(RUN_CYCLES);
		bus_read(`REG_STATUS);
		ctrl[r % 3] = 1'b0;
		bus_write(`REG_CTRL, ctrl);
		run_cycles(FREEZE_CYCLES);
		ctrl[r % 3] = 1'b1;
		bus_write(`REG_CTRL, ctrl);
		run_cycles(FREEZE_CYCLES);
	endtask

	// random peak pulses two to four clocks wide
	always @(posedge clk) begin
		#1;
		if (peak_hold != 0) begin
			peak_in = 1'b1;
			peak_hold--;
		end else begin
			peak_in = 1'b0;
			if (peak_rate != 0) begin
				peak_seed = lcg_next(peak_seed);
				if (((peak_seed >> 16) % peak_rate) == 0) begin
					peak_hold = 2 + int'((peak_seed >> 8) % 3);
				end
			end
		end
	end

	// oscillator events from model state
	always_comb begin
		m_cpulse = m_edge && (m_count > m_pcfg.nblackout);
		m_trig = (m_del == m_pcfg.ndelay) && (m_trig_cnt == cntr_t'(m_count - 1));
		m_evt.count = m_count;
		m_evt.forced = m_pcfg.en && m_cpulse
			&& ((int'(m_count) + int'(m_pcfg.ncstr)) >= int'(m_pcfg.npco));
		m_evt.pulse = m_evt.forced
			|| (m_pcfg.en && m_trig && (cntr_t'(m_count + 1) == m_pcfg.npco));
	end

	// controller next state
	always_comb begin
		m_nat = m_evt.pulse && !m_evt.forced;
		m_frc = m_evt.pulse && m_evt.forced;
		m_in_sync = (m_state == SYNC_LEAD) || (m_state == SYNC_SLAVE);
		m_next = m_state;
		m_trk_clr = 1'b0;
		m_len_clr = 1'b0;
		if (m_state == IDLE) begin
			m_next = DESYNC;
			m_trk_clr = 1'b1;
		end else if (m_state == DESYNC) begin
			if (m_lead == m_dcfg.npulse) m_next = SYNC_LEAD;
			else if (m_slave == m_dcfg.npulse) m_next = SYNC_SLAVE;
			m_len_clr = (m_next != DESYNC);
		end else if (m_in_sync) begin
			if (m_len > m_dcfg.nduty) begin
				m_next = (m_state == SYNC_LEAD) ? CHECK_LEAD : CHECK_SLAVE;
			end
		end else if (m_evt.pulse) begin // a check state
			if ((m_state == CHECK_LEAD) == m_nat) begin
				m_next = (m_state == CHECK_LEAD) ? SYNC_LEAD : SYNC_SLAVE;
				m_len_clr = 1'b1;
			end else begin
				m_next = DESYNC;
				m_trk_clr = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (!greset_n) begin
			m_ack <= 1'b0;
			m_pcfg <= '0;
			m_pcfg.npco <= cntr_t'(1);
			m_dcfg <= '0;
			m_gcfg <= '0;
			{m_s0, m_s1, m_prev, m_edge} <= 4'b0000;
			m_count <= cntr_t'(1);
			m_del <= '0;
			m_trig_cnt <= '0;
			m_state <= IDLE;
			m_duty <= 1'b0;
			m_lead <= '0;
			m_slave <= '0;
			m_len <= '0;
			m_idx <= `SEQ_LEN - 1;
		end else begin
			m_ack <= wb_req.cyc && wb_req.stb && !m_ack;
			if (m_ack && wb_req.cyc && wb_req.stb && wb_req.we) begin
				case (wb_req.adr)
					`REG_CTRL: begin
						m_pcfg.en <= wb_req.dat_w[`CTRL_PCO_EN];
						m_dcfg.en <= wb_req.dat_w[`CTRL_DUTY_EN];
						m_gcfg.en <= wb_req.dat_w[`CTRL_GEN_EN];
						m_pcfg.design_sel <= wb_req.dat_w[`CTRL_DESIGN_SEL];
					end
					`REG_NDELAY:    m_pcfg.ndelay <= wb_req.dat_w[`CNTR_W-1:0];
					`REG_NBLACKOUT: m_pcfg.nblackout <= wb_req.dat_w[`CNTR_W-1:0];
					`REG_NCSTR:     m_pcfg.ncstr <= wb_req.dat_w[`CNTR_W-1:0];
					`REG_NPCO:      m_pcfg.npco <= wb_req.dat_w[`CNTR_W-1:0];
					`REG_NDUTY_L:   m_dcfg.nduty_l <= wb_req.dat_w[`CNTR_W-1:0];
					`REG_NDUTY_H:   m_dcfg.nduty_h <= wb_req.dat_w[`CNTR_W-1:0];
					`REG_NPULSE:    m_dcfg.npulse <= wb_req.dat_w[`CNTR_W-1:0];
					`REG_NDUTY:     m_dcfg.nduty <= wb_req.dat_w[`CNTR_W-1:0];
					`REG_SEQ:       m_gcfg.seq <= wb_req.dat_w;
					default: ;
				endcase
			end
			if (m_pcfg.en) begin
				m_s0 <= peak_in;
				m_s1 <= m_s0;
				m_prev <= m_s1;
				m_edge <= m_s1 && !m_prev;
				if (m_evt.pulse) begin
					m_count <= cntr_t'(1);
					m_trig_cnt <= '0;
					m_del <= (m_pcfg.design_sel && m_evt.forced) ? cntr_t'(1) : '0;
				end else begin
					if (m_del != m_pcfg.ndelay) m_del <= cntr_t'(m_del + 1);
					m_trig_cnt <= (m_trig_cnt == cntr_t'(m_count - 1))
						? '0 : cntr_t'(m_trig_cnt + 1);
					if (m_cpulse) m_count <= cntr_t'(m_count + m_pcfg.ncstr);
					else if (m_trig) m_count <= cntr_t'(m_count + 1);
				end
			end
			if (m_dcfg.en) begin
				m_duty <= m_in_sync && (m_count >= m_dcfg.nduty_l)
					&& (m_count <= m_dcfg.nduty_h);
				m_state <= m_next;
				if (m_trk_clr || (m_frc && (m_count <= m_dcfg.nduty_h))) begin
					m_lead <= '0;
					m_slave <= '0;
				end else if (m_frc) begin
					m_slave <= cntr_t'(m_slave + 1);
				end else if (m_nat) begin
					m_lead <= cntr_t'(m_lead + 1);
				end
				if (m_len_clr) m_len <= '0;
				else if (m_evt.pulse && m_in_sync && (m_len <= m_dcfg.nduty))
					m_len <= cntr_t'(m_len + 1);
			end
			if (m_gcfg.en) begin
				if (m_evt.pulse && (m_idx == `SEQ_LEN - 1)) m_idx <= 0; // restart only when idle
				else if (m_idx != `SEQ_LEN - 1) m_idx <= m_idx + 1;
			end
		end
	end

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (greset_n) begin
			check_evt(evt, m_evt);
			check_state(state, m_state);
			check_bit(duty_out, m_duty, "duty_out");
			check_bit(seq_out, m_gcfg.seq[`SEQ_LEN - 1 - m_idx], "seq_out"); // msb first
			check_bit(wb_rsp.ack, m_ack, "ack");
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
			$display("Test failures found");
			$fatal(1, "timeout");
		end
	end

	initial begin
		greset_n = 1'b0;
		wb_req = '0;
		peak_in = 1'b0;
		peak_rate = 0;
		peak_hold = 0;
		cycle_count = 0;
		error_count = 0;
		cfg_seed = 66;
		peak_seed = lcg_next(66); // second stream off the same seed
		apply_reset();
		test_registers();
		for (int r = 0; r < NUM_RUNS; r++) begin
			random_run(r);
		end
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/pco_pkg.sv
hdl/pco_regs.sv
hdl/pco_osc.sv
hdl/duty_ctrl.sv
hdl/seq_pulsegen.sv
hdl/pco_node_top.sv
testbench/pco_node_chk.sv
testbench/tb_pco_node.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_pco_node
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = All tests passed!
FLAGS      = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
